/* src/rv_exec_pkg.sv */
package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  branch_op_t;

    // base opcodes handled by the stage
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // branch comparison codes
    localparam branch_op_t BR_EQ   = 3'd0;
    localparam branch_op_t BR_NE   = 3'd1;
    localparam branch_op_t BR_LT   = 3'd2;
    localparam branch_op_t BR_LTU  = 3'd3;
    localparam branch_op_t BR_GE   = 3'd4;
    localparam branch_op_t BR_GEU  = 3'd5;
    localparam branch_op_t BR_JUMP = 3'd6;
    localparam branch_op_t BR_NONE = 3'd7;

    // one instruction as handed to the stage
    typedef struct packed {
        word_t    instr;
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        reg_idx_t rd;
    } issue_t;

    // bundle between decode and execute
    typedef struct packed {
        word_t      a_operand;
        word_t      b_operand;
        alu_op_t    alu_op;
        branch_op_t branch_op;
        logic       is_jalr;
        logic       link;
        word_t      imm;
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        reg_idx_t   rd;
        logic       wr_en;
        logic       illegal;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
        logic     wr_en;
        logic     illegal;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* src/ex_ctrl.sv */
module ex_ctrl (
    input  rv_exec_pkg::opcode_t    opcode,
    input  logic [2:0]              funct3,
    output logic                    a_sel,     // 0: rs1, 1: pc
    output logic                    b_sel,     // 0: rs2, 1: imm
    output rv_exec_pkg::branch_op_t branch_op
);
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic is_op;

    assign is_auipc  = (opcode == rv_exec_pkg::OPC_AUIPC);
    assign is_jal    = (opcode == rv_exec_pkg::OPC_JAL);
    assign is_jalr   = (opcode == rv_exec_pkg::OPC_JALR);
    assign is_branch = (opcode == rv_exec_pkg::OPC_BRANCH);
    assign is_op     = (opcode == rv_exec_pkg::OPC_OP);

    // most instructions read rs1, only these need the pc
    assign a_sel = is_auipc || is_jal || is_branch;

    // register-register ops are the only users of rs2 on the alu
    assign b_sel = !is_op;

    always_comb
    begin
        branch_op = rv_exec_pkg::BR_NONE;
        if (is_jal || is_jalr)
        begin
            branch_op = rv_exec_pkg::BR_JUMP;
        end
        else if (is_branch)
        begin
            // funct3 order differs from the comparison codes
            case (funct3)
                3'b000:  branch_op = rv_exec_pkg::BR_EQ;
                3'b001:  branch_op = rv_exec_pkg::BR_NE;
                3'b100:  branch_op = rv_exec_pkg::BR_LT;
                3'b101:  branch_op = rv_exec_pkg::BR_GE;
                3'b110:  branch_op = rv_exec_pkg::BR_LTU;
                3'b111:  branch_op = rv_exec_pkg::BR_GEU;
                default: branch_op = rv_exec_pkg::BR_NONE;
            endcase
        end
    end

endmodule

/* src/instr_decode.sv */
module instr_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  in_valid,
    input  rv_exec_pkg::issue_t   issue,
    output rv_exec_pkg::decoded_t dec,
    output logic                  dec_valid
);
    rv_exec_pkg::opcode_t    opcode;
    logic [2:0]              funct3;
    logic                    funct7_b5;
    logic                    a_sel;
    logic                    b_sel;
    rv_exec_pkg::branch_op_t branch_op;
    rv_exec_pkg::word_t      imm;
    rv_exec_pkg::alu_op_t    alu_op;
    logic                    legal;
    rv_exec_pkg::decoded_t   dec_next;

    assign opcode    = issue.instr[6:0];
    assign funct3    = issue.instr[14:12];
    assign funct7_b5 = issue.instr[30];

    ex_ctrl i_ex_ctrl (
        .opcode    (opcode),
        .funct3    (funct3),
        .a_sel     (a_sel),
        .b_sel     (b_sel),
        .branch_op (branch_op)
    );

    // immediate format by opcode, I-type for everything else
    always_comb
    begin
        case (opcode)
            rv_exec_pkg::OPC_LUI,
            rv_exec_pkg::OPC_AUIPC:  imm = {issue.instr[31:12], 12'b0};
            rv_exec_pkg::OPC_JAL:    imm = {{11{issue.instr[31]}}, issue.instr[31],
                                            issue.instr[19:12], issue.instr[20],
                                            issue.instr[30:21], 1'b0};
            rv_exec_pkg::OPC_BRANCH: imm = {{19{issue.instr[31]}}, issue.instr[31],
                                            issue.instr[7], issue.instr[30:25],
                                            issue.instr[11:8], 1'b0};
            default:                 imm = {{20{issue.instr[31]}}, issue.instr[31:20]};
        endcase
    end

    always_comb
    begin
        case (opcode)
            rv_exec_pkg::OPC_LUI,
            rv_exec_pkg::OPC_AUIPC,
            rv_exec_pkg::OPC_JAL,
            rv_exec_pkg::OPC_JALR,
            rv_exec_pkg::OPC_BRANCH,
            rv_exec_pkg::OPC_OP_IMM,
            rv_exec_pkg::OPC_OP: legal = 1'b1;
            default:             legal = 1'b0;
        endcase
    end

    // add covers auipc, jal, jalr and branches
    always_comb
    begin
        alu_op = rv_exec_pkg::ALU_ADD;
        if (opcode == rv_exec_pkg::OPC_LUI)
        begin
            alu_op = rv_exec_pkg::ALU_PASS_B;
        end
        else if (opcode == rv_exec_pkg::OPC_OP || opcode == rv_exec_pkg::OPC_OP_IMM)
        begin
            case (funct3)
                3'b000:  alu_op = (opcode == rv_exec_pkg::OPC_OP && funct7_b5) ?
                                  rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
                3'b001:  alu_op = rv_exec_pkg::ALU_SLL;
                3'b010:  alu_op = rv_exec_pkg::ALU_SLT;
                3'b011:  alu_op = rv_exec_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_exec_pkg::ALU_XOR;
                3'b101:  alu_op = funct7_b5 ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                3'b110:  alu_op = rv_exec_pkg::ALU_OR;
                default: alu_op = rv_exec_pkg::ALU_AND;
            endcase
        end
    end

    always_comb
    begin
        dec_next.a_operand = a_sel ? issue.pc : issue.rs1_data;
        dec_next.b_operand = b_sel ? imm : issue.rs2_data;
        dec_next.alu_op    = alu_op;
        dec_next.branch_op = branch_op;
        dec_next.is_jalr   = (opcode == rv_exec_pkg::OPC_JALR);
        dec_next.link      = (opcode == rv_exec_pkg::OPC_JAL) || dec_next.is_jalr;
        dec_next.imm       = imm;
        dec_next.pc        = issue.pc;
        dec_next.rs1_data  = issue.rs1_data;
        dec_next.rs2_data  = issue.rs2_data;
        dec_next.rd        = issue.rd;
        // no write for branches, x0 or anything not decoded
        dec_next.wr_en     = legal && (opcode != rv_exec_pkg::OPC_BRANCH) && (issue.rd != '0);
        dec_next.illegal   = !legal;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_valid <= 1'b0;
        end
        else if (!stall)
        begin
            dec_valid <= in_valid;
            dec       <= dec_next;
        end
    end

endmodule

/* src/alu.sv */
module alu (
    input  rv_exec_pkg::word_t   a,
    input  rv_exec_pkg::word_t   b,
    input  rv_exec_pkg::alu_op_t op,
    output rv_exec_pkg::word_t   result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits count as shift amount
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            rv_exec_pkg::ALU_ADD:
                result = a + b;
            rv_exec_pkg::ALU_SUB:
                result = a - b;
            rv_exec_pkg::ALU_SLL:
                result = a << shamt;
            rv_exec_pkg::ALU_SLT:
                result = {31'b0, lt_signed};
            rv_exec_pkg::ALU_SLTU:
                result = {31'b0, lt_unsigned};
            rv_exec_pkg::ALU_XOR:
                result = a ^ b;
            rv_exec_pkg::ALU_SRL:
                result = a >> shamt;
            rv_exec_pkg::ALU_SRA:
            begin
                // arithmetic shift keeps the sign bit
                result = $signed(a) >>> shamt;
            end
            rv_exec_pkg::ALU_OR:
                result = a | b;
            rv_exec_pkg::ALU_AND:
                result = a & b;
            rv_exec_pkg::ALU_PASS_B:
                result = b;
            default:
                result = '0;
        endcase
    end

endmodule

/* src/branch_unit.sv */
module branch_unit (
    input  rv_exec_pkg::decoded_t dec,
    output logic                  taken,
    output rv_exec_pkg::word_t    target
);
    logic               eq;
    logic               lt;
    logic               ltu;
    rv_exec_pkg::word_t base;
    rv_exec_pkg::word_t sum;

    assign eq  = (dec.rs1_data == dec.rs2_data);
    assign lt  = $signed(dec.rs1_data) < $signed(dec.rs2_data);
    assign ltu = (dec.rs1_data < dec.rs2_data);

    always_comb
    begin
        case (dec.branch_op)
            rv_exec_pkg::BR_EQ:   taken = eq;
            rv_exec_pkg::BR_NE:   taken = !eq;
            rv_exec_pkg::BR_LT:   taken = lt;
            rv_exec_pkg::BR_LTU:  taken = ltu;
            rv_exec_pkg::BR_GE:   taken = !lt;
            rv_exec_pkg::BR_GEU:  taken = !ltu;
            rv_exec_pkg::BR_JUMP: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    // jalr is register relative, everything else pc relative
    assign base = dec.is_jalr ? dec.rs1_data : dec.pc;
    assign sum  = base + dec.imm;

    // jalr drops bit 0 of the sum
    assign target = {sum[31:1], sum[0] & !dec.is_jalr};

endmodule

/* src/exec_result.sv */
module exec_result (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  rv_exec_pkg::decoded_t  dec,
    input  logic                   dec_valid,
    input  rv_exec_pkg::word_t     alu_result,
    input  logic                   taken,
    input  rv_exec_pkg::word_t     target,
    output rv_exec_pkg::wb_t       wb,
    output rv_exec_pkg::redirect_t redirect
);
    rv_exec_pkg::word_t value;
    rv_exec_pkg::word_t link_addr;
    logic               wr_en_next;
    logic               taken_next;

    // return address for jal and jalr
    assign link_addr = dec.pc + 32'd4;
    assign value     = dec.link ? link_addr : alu_result;

    assign wr_en_next = dec_valid && dec.wr_en;

    // an illegal instruction never redirects
    assign taken_next = dec_valid && taken && !dec.illegal;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb.valid       <= 1'b0;
            wb.wr_en       <= 1'b0;
            redirect.taken <= 1'b0;
        end
        else if (!stall)
        begin
            wb.valid        <= dec_valid;
            wb.rd           <= dec.rd;
            wb.value        <= value;
            wb.wr_en        <= wr_en_next;
            wb.illegal      <= dec.illegal;
            redirect.taken  <= taken_next;
            redirect.target <= target;
        end
    end

endmodule

/* src/exec_stage.sv */
module exec_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   in_valid,
    input  rv_exec_pkg::issue_t    issue,
    output rv_exec_pkg::wb_t       wb,
    output rv_exec_pkg::redirect_t redirect
);
    rv_exec_pkg::decoded_t dec;
    logic                  dec_valid;
    rv_exec_pkg::word_t    alu_result;
    logic                  taken;
    rv_exec_pkg::word_t    target;

    // first register stage
    instr_decode i_instr_decode (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .in_valid  (in_valid),
        .issue     (issue),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    alu i_alu (
        .a      (dec.a_operand),
        .b      (dec.b_operand),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    branch_unit i_branch_unit (
        .dec    (dec),
        .taken  (taken),
        .target (target)
    );

    // second register stage
    exec_result i_exec_result (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .dec        (dec),
        .dec_valid  (dec_valid),
        .alu_result (alu_result),
        .taken      (taken),
        .target     (target),
        .wb         (wb),
        .redirect   (redirect)
    );

endmodule

/* verification/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // synchronous reset held over the first five edges
    initial
    begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verification/exec_stage_tb.sv */
module exec_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rv_exec_pkg::issue_t issue;
        rv_exec_pkg::word_t  value;
        logic                wr_en;
        logic                taken;
        rv_exec_pkg::word_t  target;
        logic                illegal;
    } vector_t;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   in_valid;
    rv_exec_pkg::issue_t    issue;
    rv_exec_pkg::wb_t       wb;
    rv_exec_pkg::redirect_t redirect;

    vector_t                table_q[$];
    vector_t                expect_q[$];
    int                     errors;
    int                     received;
    logic                   hold_pending;
    rv_exec_pkg::wb_t       held_wb;
    rv_exec_pkg::redirect_t held_redirect;

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    exec_stage i_exec_stage (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .in_valid (in_valid),
        .issue    (issue),
        .wb       (wb),
        .redirect (redirect)
    );

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    // instruction encoders with rs1 fixed at x1 and rs2 at x2
    function automatic rv_exec_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3,
                                                 rv_exec_pkg::reg_idx_t rd);
        return {f7, 5'd2, 5'd1, f3, rd, rv_exec_pkg::OPC_OP};
    endfunction

    function automatic rv_exec_pkg::word_t enc_i(logic [11:0] imm, logic [2:0] f3,
                                                 rv_exec_pkg::reg_idx_t rd,
                                                 rv_exec_pkg::opcode_t opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic rv_exec_pkg::word_t enc_u(logic [19:0] imm, rv_exec_pkg::reg_idx_t rd,
                                                 rv_exec_pkg::opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_exec_pkg::word_t enc_b(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11],
                rv_exec_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_exec_pkg::word_t enc_j(logic [20:0] imm, rv_exec_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::OPC_JAL};
    endfunction

    task automatic add_vec(input rv_exec_pkg::word_t instr, input rv_exec_pkg::word_t pc,
                           input rv_exec_pkg::word_t rs1, input rv_exec_pkg::word_t rs2,
                           input rv_exec_pkg::reg_idx_t rd, input rv_exec_pkg::word_t value,
                           input logic wr_en, input logic taken,
                           input rv_exec_pkg::word_t target, input logic illegal);
        vector_t v;
        v.issue.instr    = instr;
        v.issue.pc       = pc;
        v.issue.rs1_data = rs1;
        v.issue.rs2_data = rs2;
        v.issue.rd       = rd;
        v.value          = value;
        v.wr_en          = wr_en;
        v.taken          = taken;
        v.target         = target;
        v.illegal        = illegal;
        table_q.push_back(v);
    endtask

    // expected values worked out by hand from the RV32I rules
    task automatic build_table();
        // register-register ops with shift amounts above 31 in rs2
        add_vec(enc_r(7'h00, 3'd0, 5'd1), 32'h100, 32'd5, 32'd7, 5'd1, 32'd12, 1, 0, 0, 0);
        add_vec(enc_r(7'h20, 3'd0, 5'd1), 32'h100, 32'd3, 32'd10, 5'd1, 32'hFFFFFFF9,
                1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd1, 5'd2), 32'h100, 32'd1, 32'd36, 5'd2, 32'd16, 1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd2, 5'd3), 32'h100, 32'hFFFFFFFF, 32'd1, 5'd3, 32'd1,
                1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd3, 5'd4), 32'h100, 32'hFFFFFFFF, 32'd1, 5'd4, 32'd0,
                1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd4, 5'd5), 32'h100, 32'hF0F0F0F0, 32'hFF00FF00, 5'd5,
                32'h0FF00FF0, 1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd5, 5'd6), 32'h100, 32'h80000000, 32'd33, 5'd6,
                32'h40000000, 1, 0, 0, 0);
        add_vec(enc_r(7'h20, 3'd5, 5'd7), 32'h100, 32'h80000000, 32'd4, 5'd7,
                32'hF8000000, 1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd6, 5'd8), 32'h100, 32'h0000F000, 32'h000000FF, 5'd8,
                32'h0000F0FF, 1, 0, 0, 0);
        add_vec(enc_r(7'h00, 3'd7, 5'd9), 32'h100, 32'hFFFF0000, 32'h12345678, 5'd9,
                32'h12340000, 1, 0, 0, 0);
        // immediate ops
        add_vec(enc_i(12'hFFD, 3'd0, 5'd10, rv_exec_pkg::OPC_OP_IMM), 32'h100, 32'd10, 0,
                5'd10, 32'd7, 1, 0, 0, 0);
        add_vec(enc_i(12'h404, 3'd5, 5'd11, rv_exec_pkg::OPC_OP_IMM), 32'h100,
                32'hFFFFFF00, 0, 5'd11, 32'hFFFFFFF0, 1, 0, 0, 0);
        add_vec(enc_i(12'hFFE, 3'd2, 5'd12, rv_exec_pkg::OPC_OP_IMM), 32'h100,
                32'hFFFFFFFB, 0, 5'd12, 32'd1, 1, 0, 0, 0);
        // upper immediates
        add_vec(enc_u(20'h12345, 5'd13, rv_exec_pkg::OPC_LUI), 32'h100, 0, 0, 5'd13,
                32'h12345000, 1, 0, 0, 0);
        add_vec(enc_u(20'h00001, 5'd14, rv_exec_pkg::OPC_AUIPC), 32'h200, 0, 0, 5'd14,
                32'h00001200, 1, 0, 0, 0);
        // each branch condition taken then not taken
        add_vec(enc_b(13'd16, 3'd0), 32'h400, 32'd5, 32'd5, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd0), 32'h400, 32'd5, 32'd6, 5'd3, 0, 0, 0, 0, 0);
        add_vec(enc_b(13'd16, 3'd1), 32'h400, 32'd5, 32'd6, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd1), 32'h400, 32'd5, 32'd5, 5'd3, 0, 0, 0, 0, 0);
        add_vec(enc_b(13'd16, 3'd4), 32'h400, 32'hFFFFFFFF, 32'd1, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd4), 32'h400, 32'd1, 32'hFFFFFFFF, 5'd3, 0, 0, 0, 0, 0);
        add_vec(enc_b(13'd16, 3'd5), 32'h400, 32'd1, 32'hFFFFFFFF, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd5), 32'h400, 32'hFFFFFFFF, 32'd1, 5'd3, 0, 0, 0, 0, 0);
        add_vec(enc_b(13'd16, 3'd6), 32'h400, 32'd1, 32'hFFFFFFFF, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd6), 32'h400, 32'hFFFFFFFF, 32'd1, 5'd3, 0, 0, 0, 0, 0);
        add_vec(enc_b(13'd16, 3'd7), 32'h400, 32'hFFFFFFFF, 32'd1, 5'd3, 0, 0, 1, 32'h410, 0);
        add_vec(enc_b(13'd16, 3'd7), 32'h400, 32'd1, 32'hFFFFFFFF, 5'd3, 0, 0, 0, 0, 0);
        // backward branch
        add_vec(enc_b(13'h1FF8, 3'd0), 32'h400, 32'd9, 32'd9, 5'd3, 0, 0, 1, 32'h3F8, 0);
        // jumps
        add_vec(enc_j(21'h800, 5'd1), 32'h500, 0, 0, 5'd1, 32'h504, 1, 1, 32'hD00, 0);
        add_vec(enc_j(21'h1FFFFC, 5'd0), 32'h500, 0, 0, 5'd0, 32'h504, 0, 1, 32'h4FC, 0);
        add_vec(enc_i(12'd6, 3'd0, 5'd5, rv_exec_pkg::OPC_JALR), 32'h600, 32'h1001, 0,
                5'd5, 32'h604, 1, 1, 32'h1006, 0);
        // load opcode is not handled by the stage
        add_vec(enc_i(12'd0, 3'd2, 5'd2, 7'b0000011), 32'h700, 32'd4, 0, 5'd2, 0,
                0, 0, 0, 1);
    endtask

    // scoreboard and hold check on every edge out of reset
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (hold_pending)
            begin
                check("wb held", 64'(wb), 64'(held_wb));
                check("redirect held", 64'(redirect), 64'(held_redirect));
            end
            hold_pending  <= stall;
            held_wb       <= wb;
            held_redirect <= redirect;
            if (wb.valid && !stall)
            begin
                if (expect_q.size() == 0)
                begin
                    errors++;
                    $display("result at time %0t with no instruction outstanding", $time);
                end
                else
                begin
                    compare_result(expect_q.pop_front());
                    received++;
                end
            end
        end
    end

    task automatic compare_result(input vector_t v);
        check("wb.rd", 64'(wb.rd), 64'(v.issue.rd));
        check("wb.wr_en", 64'(wb.wr_en), 64'(v.wr_en));
        check("wb.illegal", 64'(wb.illegal), 64'(v.illegal));
        check("redirect.taken", 64'(redirect.taken), 64'(v.taken));
        if (v.wr_en)
        begin
            check("wb.value", 64'(wb.value), 64'(v.value));
        end
        if (v.taken)
        begin
            check("redirect.target", 64'(redirect.target), 64'(v.target));
        end
    endtask

    initial
    begin
        int idx;
        int limit;
        logic stall_now;

        stall        = 1'b0;
        in_valid     = 1'b0;
        issue        = '0;
        errors       = 0;
        received     = 0;
        hold_pending = 1'b0;
        void'($urandom(66083));
        build_table();
        limit = table_q.size() * 8 + 50;

        // watchdog
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout after %0d cycles, %0d of %0d results seen",
                         limit, received, table_q.size());
                $display("SIMULATION FAILED");
                $finish;
            end
        join_none

        @(posedge clk);
        while (reset)
        begin
            @(posedge clk);
        end

        // back-to-back issue where a random stall holds the current entry
        idx = 0;
        while (idx < table_q.size())
        begin
            stall_now = ($urandom % 4 == 0);
            stall    <= stall_now;
            in_valid <= 1'b1;
            issue    <= table_q[idx].issue;
            if (!stall_now)
            begin
                expect_q.push_back(table_q[idx]);
                idx++;
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        stall    <= 1'b0;

        while (received < table_q.size())
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("results: %0d of %0d, errors: %0d", received, table_q.size(), errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
src/rv_exec_pkg.sv
src/ex_ctrl.sv
src/instr_decode.sv
src/alu.sv
src/branch_unit.sv
src/exec_result.sv
src/exec_stage.sv
verification/tb_clock.sv
verification/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module exec_stage_tb -o exec_stage_sim
then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/exec_stage_sim > sim.log 2>&1
then
    cat sim.log
    echo "simulation run returned an error"
    exit 1
fi

cat sim.log

if grep -q "SIMULATION FAILED" sim.log
then
    exit 1
fi

exit 0
